//--- sources.f
rtl/vgaTimingPkg.sv
rtl/vgaBusPkg.sv
rtl/vgaSyncGenerator.sv
rtl/vgaRegFile.sv
rtl/vgaPatternGen.sv
rtl/vgaOutputStage.sv
rtl/vgaTop.sv
sim/vgaTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the VGA testbench with Verilator, runs it and checks the result
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f sources.f --top-module vgaTb -o vgaSim; then
  echo "Verilator build failed"
  exit 1
fi

output="$(./obj_dir/vgaSim)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1

//--- sim/vgaTb.sv
// ==========================================================================
// Directed testbench for the VGA controller with reduced frame timing
// Covers register access, sync timing, test patterns and the frame counter
// ==========================================================================
`timescale 1ns/1ps

module vgaTb;

  localparam int hActive     = 16;
  localparam int hFrontPorch = 2;
  localparam int hSyncPulse  = 3;
  localparam int hBackPorch  = 3;
  localparam int vActive     = 8;
  localparam int vFrontPorch = 1;
  localparam int vSyncPulse  = 2;
  localparam int vBackPorch  = 1;
  localparam int hTotal      = hActive + hFrontPorch + hSyncPulse + hBackPorch;
  localparam int vTotal      = vActive + vFrontPorch + vSyncPulse + vBackPorch;
  localparam int frameClocks = hTotal * vTotal;
  localparam int ackLimit    = 16;

  logic                  clk;
  logic                  arstN;
  vgaBusPkg::wbRequest   wbReq;
  vgaBusPkg::wbResponse  wbRsp;
  vgaTimingPkg::rgbPixel pixelOut;
  logic                  hSync;
  logic                  vSync;
  logic                  dataEnable;
  int                    errorCount;
  int                    testCount;

  vgaTop #(
    .hActive    (hActive),
    .hFrontPorch(hFrontPorch),
    .hSyncPulse (hSyncPulse),
    .hBackPorch (hBackPorch),
    .vActive    (vActive),
    .vFrontPorch(vFrontPorch),
    .vSyncPulse (vSyncPulse),
    .vBackPorch (vBackPorch)
  ) i_dut (
    .clk       (clk),
    .arstN     (arstN),
    .wbReq     (wbReq),
    .wbRsp     (wbRsp),
    .pixelOut  (pixelOut),
    .hSync     (hSync),
    .vSync     (vSync),
    .dataEnable(dataEnable)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Outputs are sampled and inputs driven 1 ns after each rising edge
  task automatic stepClock;
    @(posedge clk);
    #1;
  endtask

  task automatic reportMismatch(input string name, input int expected, input int actual);
    $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    errorCount++;
  endtask

  task automatic reportProblem(input string what);
    $display("Error at %0t ns: %s", $time, what);
    errorCount++;
  endtask

  task automatic finishTest(input string name, input int startErrors);
    testCount++;
    $display("Test %s finished with %0d errors", name, errorCount - startErrors);
  endtask

  function automatic logic pinValue(input string name);
    if (name == "hSync") begin
      return hSync;
    end else if (name == "vSync") begin
      return vSync;
    end
    return dataEnable;
  endfunction

  // Clocks until the pin reaches level from the opposite level
  task automatic waitEdge(input string name, input logic level, output int clocks);
    logic prev;
    logic now;
    bit   found;
    prev   = pinValue(name);
    clocks = 0;
    found  = 1'b0;
    while (!found && clocks < 2 * frameClocks) begin
      stepClock();
      clocks++;
      now   = pinValue(name);
      found = (now == level) && (prev != level);
      prev  = now;
    end
    if (!found)
      reportProblem($sformatf("no edge to %0b on %s within %0d clocks", level, name, clocks));
  endtask

  task automatic wbAccess(input logic we, input logic [1:0] adr, input logic [15:0] datW,
                          output logic [15:0] datR);
    int waited;
    wbReq.cyc  = 1'b1;
    wbReq.stb  = 1'b1;
    wbReq.we   = we;
    wbReq.adr  = adr;
    wbReq.datW = datW;
    stepClock();
    waited = 1;
    while (!wbRsp.ack && waited < ackLimit) begin
      stepClock();
      waited++;
    end
    if (!wbRsp.ack)
      reportProblem($sformatf("no ack from the slave at address %0d", adr));
    datR = wbRsp.datR;
    // Strobe held one more clock where no second ack may follow
    stepClock();
    if (wbRsp.ack !== 1'b0)
      reportProblem("ack stayed high for more than one cycle");
    wbReq.cyc = 1'b0;
    wbReq.stb = 1'b0;
    wbReq.we  = 1'b0;
  endtask

  task automatic wbWrite(input logic [1:0] adr, input logic [15:0] data);
    logic [15:0] ignored;
    wbAccess(1'b1, adr, data, ignored);
  endtask

  task automatic wbRead(input logic [1:0] adr, output logic [15:0] data);
    wbAccess(1'b0, adr, 16'd0, data);
  endtask

  task automatic registerAccess;
    logic [15:0] data;
    logic [15:0] fg;
    logic [15:0] bg;
    logic [15:0] count0;
    int          startErrors;
    startErrors = errorCount;
    wbRead(vgaBusPkg::regControl, data);
    if (data !== 16'h0000) reportMismatch("regControl", 0, int'(data));
    wbRead(vgaBusPkg::regFgColor, data);
    if (data !== 16'h0fff) reportMismatch("regFgColor", 'h0fff, int'(data));
    wbRead(vgaBusPkg::regBgColor, data);
    if (data !== 16'h0000) reportMismatch("regBgColor", 0, int'(data));
    wbRead(vgaBusPkg::regFrameCount, count0);
    if (count0 !== 16'h0000) reportMismatch("regFrameCount", 0, int'(count0));
    fg = 16'($urandom);
    bg = 16'($urandom);
    wbWrite(vgaBusPkg::regFgColor, fg);
    wbWrite(vgaBusPkg::regBgColor, bg);
    wbRead(vgaBusPkg::regFgColor, data);
    if (data !== (fg & 16'h0fff)) reportMismatch("regFgColor", int'(fg & 16'h0fff), int'(data));
    wbRead(vgaBusPkg::regBgColor, data);
    if (data !== (bg & 16'h0fff)) reportMismatch("regBgColor", int'(bg & 16'h0fff), int'(data));
    // Frame count is read only
    wbWrite(vgaBusPkg::regFrameCount, 16'($urandom));
    wbRead(vgaBusPkg::regFrameCount, data);
    if (data !== count0) reportMismatch("regFrameCount", int'(count0), int'(data));
    finishTest("register access", startErrors);
  endtask

  task automatic horizontalTiming;
    int clocks;
    int width;
    int startErrors;
    startErrors = errorCount;
    waitEdge("dataEnable", 1'b1, clocks);
    waitEdge("dataEnable", 1'b0, width);
    if (width != hActive) reportMismatch("dataEnable width", hActive, width);
    waitEdge("hSync", 1'b1, clocks);
    if (clocks != hFrontPorch) reportMismatch("dataEnable fall to hSync rise", hFrontPorch, clocks);
    waitEdge("hSync", 1'b0, width);
    if (width != hSyncPulse) reportMismatch("hSync width", hSyncPulse, width);
    waitEdge("hSync", 1'b1, clocks);
    if (width + clocks != hTotal) reportMismatch("hSync period", hTotal, width + clocks);
    finishTest("horizontal timing", startErrors);
  endtask

  task automatic verticalTiming;
    int   clocks;
    int   high;
    int   lines;
    logic prevV;
    logic prevDe;
    bit   rose;
    int   startErrors;
    startErrors = errorCount;
    waitEdge("vSync", 1'b1, clocks);
    clocks = 0;
    high   = 1;
    lines  = 0;
    prevV  = 1'b1;
    prevDe = dataEnable;
    rose   = 1'b0;
    // One full frame between two vSync rises
    while (!rose && clocks < 2 * frameClocks) begin
      stepClock();
      clocks++;
      rose = vSync && !prevV;
      if (vSync && !rose) high++;
      if (dataEnable && !prevDe) lines++;
      prevV  = vSync;
      prevDe = dataEnable;
    end
    if (!rose) reportProblem("vSync did not rise again within two frames");
    if (high != vSyncPulse * hTotal) reportMismatch("vSync width", vSyncPulse * hTotal, high);
    if (clocks != frameClocks) reportMismatch("vSync period", frameClocks, clocks);
    if (lines != vActive) reportMismatch("active lines per frame", vActive, lines);
    finishTest("vertical timing", startErrors);
  endtask

  function automatic vgaTimingPkg::rgbPixel patternColour(
      input vgaTimingPkg::patternMode mode, input int x, input int y,
      input vgaTimingPkg::rgbPixel fg, input vgaTimingPkg::rgbPixel bg);
    vgaTimingPkg::rgbPixel colour;
    colour = fg;
    if (mode == vgaTimingPkg::modeChecker) begin
      colour = (x[2] ^ y[2]) ? fg : bg;
    end else if (mode == vgaTimingPkg::modeGradient) begin
      colour.red   = x[3:0];
      colour.green = y[3:0];
    end
    return colour;
  endfunction

  // Follows one whole frame from pixel (0, 0) with a local x, y model
  task automatic checkPattern(input vgaTimingPkg::patternMode mode);
    vgaTimingPkg::rgbPixel fg;
    vgaTimingPkg::rgbPixel bg;
    vgaTimingPkg::rgbPixel expected;
    logic                  expectDe;
    int                    x;
    int                    y;
    int                    clocks;
    fg = vgaTimingPkg::rgbPixel'(12'($urandom));
    bg = vgaTimingPkg::rgbPixel'(12'($urandom));
    wbWrite(vgaBusPkg::regFgColor, {4'd0, fg});
    wbWrite(vgaBusPkg::regBgColor, {4'd0, bg});
    wbWrite(vgaBusPkg::regControl, {14'd0, mode});
    waitEdge("vSync", 1'b0, clocks);
    waitEdge("dataEnable", 1'b1, clocks);
    x = 0;
    y = 0;
    for (int n = 0; n < frameClocks; n++) begin
      expectDe = (x < hActive) && (y < vActive);
      expected = expectDe ? patternColour(mode, x, y, fg, bg) : '0;
      if (dataEnable !== expectDe) reportMismatch("dataEnable", int'(expectDe), int'(dataEnable));
      if (pixelOut !== expected) reportMismatch("pixelOut", int'(expected), int'(pixelOut));
      x++;
      if (x == hTotal) begin
        x = 0;
        y = (y == vTotal - 1) ? 0 : y + 1;
      end
      stepClock();
    end
  endtask

  task automatic patternOutput;
    int startErrors;
    startErrors = errorCount;
    checkPattern(vgaTimingPkg::modeSolid);
    checkPattern(vgaTimingPkg::modeChecker);
    checkPattern(vgaTimingPkg::modeGradient);
    finishTest("patterns", startErrors);
  endtask

  task automatic frameCounting;
    logic [15:0] count0;
    logic [15:0] count1;
    logic [15:0] diff;
    int          clocks;
    int          startErrors;
    startErrors = errorCount;
    // Start right after a vSync rise so each later rise follows one increment
    waitEdge("vSync", 1'b1, clocks);
    wbRead(vgaBusPkg::regFrameCount, count0);
    repeat (3) waitEdge("vSync", 1'b1, clocks);
    wbRead(vgaBusPkg::regFrameCount, count1);
    diff = count1 - count0;
    if (diff !== 16'd3) reportMismatch("regFrameCount difference", 3, int'(diff));
    finishTest("frame counter", startErrors);
  endtask

  initial begin
    void'($urandom(32'hb1a1_a7cd));
    errorCount = 0;
    testCount  = 0;
    arstN      = 1'b0;
    wbReq      = '0;
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    registerAccess();
    horizontalTiming();
    verticalTiming();
    patternOutput();
    frameCounting();
    $display("Tests run: %0d, errors: %0d", testCount, errorCount);
    if (errorCount == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- rtl/vgaTop.sv
// ==========================================================================
// VGA controller top: timing, control registers, pattern and output stages
// Timing parameters default to 640x480 and are passed to the sync generator
// ==========================================================================
`timescale 1ns/1ps

module vgaTop #(
  parameter int hActive     = 640,
  parameter int hFrontPorch = 16,
  parameter int hSyncPulse  = 96,
  parameter int hBackPorch  = 48,
  parameter int vActive     = 480,
  parameter int vFrontPorch = 10,
  parameter int vSyncPulse  = 2,
  parameter int vBackPorch  = 33
) (
  input  logic                  clk,
  input  logic                  arstN,
  input  vgaBusPkg::wbRequest   wbReq,
  output vgaBusPkg::wbResponse  wbRsp,
  output vgaTimingPkg::rgbPixel pixelOut,
  output logic                  hSync,
  output logic                  vSync,
  output logic                  dataEnable
);

  vgaTimingPkg::scanPos     pos;
  logic                     syncH;
  logic                     syncV;
  logic                     frameStart;
  vgaTimingPkg::patternMode mode;
  vgaTimingPkg::rgbPixel    fgColor;
  vgaTimingPkg::rgbPixel    bgColor;
  vgaTimingPkg::pixelBeat   beat;

  vgaSyncGenerator #(
    .hActive    (hActive),
    .hFrontPorch(hFrontPorch),
    .hSyncPulse (hSyncPulse),
    .hBackPorch (hBackPorch),
    .vActive    (vActive),
    .vFrontPorch(vFrontPorch),
    .vSyncPulse (vSyncPulse),
    .vBackPorch (vBackPorch)
  ) i_syncGen (
    .clk       (clk),
    .arstN     (arstN),
    .pos       (pos),
    .hSync     (syncH),
    .vSync     (syncV),
    .frameStart(frameStart)
  );

  vgaRegFile i_regFile (
    .clk       (clk),
    .arstN     (arstN),
    .wbReq     (wbReq),
    .wbRsp     (wbRsp),
    .frameStart(frameStart),
    .mode      (mode),
    .fgColor   (fgColor),
    .bgColor   (bgColor)
  );

  vgaPatternGen i_patternGen (
    .clk    (clk),
    .arstN  (arstN),
    .pos    (pos),
    .hSync  (syncH),
    .vSync  (syncV),
    .mode   (mode),
    .fgColor(fgColor),
    .bgColor(bgColor),
    .beat   (beat)
  );

  vgaOutputStage i_outputStage (
    .clk       (clk),
    .arstN     (arstN),
    .beat      (beat),
    .pixelOut  (pixelOut),
    .hSync     (hSync),
    .vSync     (vSync),
    .dataEnable(dataEnable)
  );

endmodule

//--- rtl/vgaOutputStage.sv
// ==========================================================================
// Last pixel stage: blanks outside the display area and registers all pins
// ==========================================================================
`timescale 1ns/1ps

module vgaOutputStage (
  input  logic                   clk,
  input  logic                   arstN,
  input  vgaTimingPkg::pixelBeat beat,
  output vgaTimingPkg::rgbPixel  pixelOut,
  output logic                   hSync,
  output logic                   vSync,
  output logic                   dataEnable
);

  vgaTimingPkg::rgbPixel blanked;

  // Black during porches and sync
  assign blanked = beat.displayArea ? beat.colour : '0;

  // All pins from one register stage so they switch together
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pixelOut   <= '0;
      hSync      <= 1'b0;
      vSync      <= 1'b0;
      dataEnable <= 1'b0;
    end else begin
      pixelOut   <= blanked;
      hSync      <= beat.hSync;
      vSync      <= beat.vSync;
      dataEnable <= beat.displayArea;
    end
  end

endmodule

//--- rtl/vgaPatternGen.sv
// ==========================================================================
// First pixel stage: maps scan position and mode to a colour
// Colour and display area are registered, the syncs arrive already registered
// ==========================================================================
`timescale 1ns/1ps

module vgaPatternGen (
  input  logic                     clk,
  input  logic                     arstN,
  input  vgaTimingPkg::scanPos     pos,
  input  logic                     hSync,
  input  logic                     vSync,
  input  vgaTimingPkg::patternMode mode,
  input  vgaTimingPkg::rgbPixel    fgColor,
  input  vgaTimingPkg::rgbPixel    bgColor,
  output vgaTimingPkg::pixelBeat   beat
);

  vgaTimingPkg::rgbPixel colourNext;
  vgaTimingPkg::rgbPixel colourQ;
  logic                  displayAreaQ;

  always_comb begin
    case (mode)
      vgaTimingPkg::modeChecker: begin
        // 4x4 pixel squares
        colourNext = (pos.x[2] ^ pos.y[2]) ? fgColor : bgColor;
      end
      vgaTimingPkg::modeGradient: begin
        colourNext.red   = pos.x[3:0];
        colourNext.green = pos.y[3:0];
        colourNext.blue  = fgColor.blue;
      end
      // Solid, and the unused code falls back to it
      default: begin
        colourNext = fgColor;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      displayAreaQ <= 1'b0;
    end else begin
      displayAreaQ <= pos.displayArea;
    end
  end

  always_ff @(posedge clk) begin
    colourQ <= colourNext;
  end

  // Syncs already trail the counters by one clock, so they line up here
  assign beat.displayArea = displayAreaQ;
  assign beat.hSync       = hSync;
  assign beat.vSync       = vSync;
  assign beat.colour      = colourQ;

endmodule

//--- rtl/vgaRegFile.sv
// ==========================================================================
// Wishbone classic control slave: pattern mode, two colours, frame counter
// Single-cycle ack with no wait states
// ==========================================================================
`timescale 1ns/1ps

module vgaRegFile (
  input  logic                     clk,
  input  logic                     arstN,
  input  vgaBusPkg::wbRequest      wbReq,
  output vgaBusPkg::wbResponse     wbRsp,
  input  logic                     frameStart,
  output vgaTimingPkg::patternMode mode,
  output vgaTimingPkg::rgbPixel    fgColor,
  output vgaTimingPkg::rgbPixel    bgColor
);

  logic        ackQ;
  logic [15:0] datRQ;
  logic [15:0] frameCount;
  logic        access;
  logic [15:0] readData;

  // The edge after an ack never starts a new access
  assign access = wbReq.cyc && wbReq.stb && !ackQ;

  always_comb begin
    case (wbReq.adr)
      vgaBusPkg::regControl: readData = {14'd0, mode};
      vgaBusPkg::regFgColor: readData = {4'd0, fgColor};
      vgaBusPkg::regBgColor: readData = {4'd0, bgColor};
      default:               readData = frameCount;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ackQ    <= 1'b0;
      mode    <= vgaTimingPkg::modeSolid;
      fgColor <= vgaTimingPkg::rgbPixel'(vgaBusPkg::fgColorReset);
      bgColor <= vgaTimingPkg::rgbPixel'(vgaBusPkg::bgColorReset);
    end else begin
      ackQ <= access;
      if (access && wbReq.we) begin
        case (wbReq.adr)
          vgaBusPkg::regControl: mode    <= vgaTimingPkg::patternMode'(wbReq.datW[1:0]);
          vgaBusPkg::regFgColor: fgColor <= vgaTimingPkg::rgbPixel'(wbReq.datW[11:0]);
          vgaBusPkg::regBgColor: bgColor <= vgaTimingPkg::rgbPixel'(wbReq.datW[11:0]);
          // Frame count ignores writes
          default: ;
        endcase
      end
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk) begin
    if (access) begin
      datRQ <= readData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      frameCount <= '0;
    end else if (frameStart) begin
      frameCount <= frameCount + 16'd1;
    end
  end

  assign wbRsp.ack  = ackQ;
  assign wbRsp.datR = datRQ;

endmodule

//--- rtl/vgaSyncGenerator.sv
// ==========================================================================
// Pixel and line counters with registered syncs and a frame-start pulse
// Totals follow from the porch and pulse parameters given by the top level
// ==========================================================================
`timescale 1ns/1ps

module vgaSyncGenerator #(
  parameter int hActive     = 640,
  parameter int hFrontPorch = 16,
  parameter int hSyncPulse  = 96,
  parameter int hBackPorch  = 48,
  parameter int vActive     = 480,
  parameter int vFrontPorch = 10,
  parameter int vSyncPulse  = 2,
  parameter int vBackPorch  = 33
) (
  input  logic                 clk,
  input  logic                 arstN,
  output vgaTimingPkg::scanPos pos,
  output logic                 hSync,
  output logic                 vSync,
  output logic                 frameStart
);

  localparam int hTotal = hActive + hFrontPorch + hSyncPulse + hBackPorch;
  localparam int vTotal = vActive + vFrontPorch + vSyncPulse + vBackPorch;

  // Thresholds sized to the counters
  localparam logic [10:0] xLast      = 11'(hTotal - 1);
  localparam logic [10:0] xActive    = 11'(hActive);
  localparam logic [10:0] xSyncStart = 11'(hActive + hFrontPorch);
  localparam logic [10:0] xSyncEnd   = 11'(hActive + hFrontPorch + hSyncPulse);
  localparam logic [9:0]  yLast      = 10'(vTotal - 1);
  localparam logic [9:0]  yActive    = 10'(vActive);
  localparam logic [9:0]  ySyncStart = 10'(vActive + vFrontPorch);
  localparam logic [9:0]  ySyncEnd   = 10'(vActive + vFrontPorch + vSyncPulse);

  logic [10:0] x;
  logic [9:0]  y;
  logic        xWrap;
  logic        yWrap;

  assign xWrap = (x == xLast);
  assign yWrap = (y == yLast);

  // y only moves on the last pixel of a line
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      x <= '0;
      y <= '0;
    end else begin
      x <= xWrap ? '0 : x + 11'd1;
      if (xWrap) begin
        y <= yWrap ? '0 : y + 10'd1;
      end
    end
  end

  // Syncs lag the counters by one clock
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      hSync      <= 1'b0;
      vSync      <= 1'b0;
      frameStart <= 1'b0;
    end else begin
      hSync      <= (x >= xSyncStart) && (x < xSyncEnd);
      vSync      <= (y >= ySyncStart) && (y < ySyncEnd);
      frameStart <= xWrap && yWrap;
    end
  end

  assign pos.x           = x;
  assign pos.y           = y;
  assign pos.displayArea = (x < xActive) && (y < yActive);

endmodule

//--- rtl/vgaBusPkg.sv
// ==========================================================================
// Wishbone classic bus structs and register map of the display control slave
// ==========================================================================
package vgaBusPkg;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [15:0] datW;
  } wbRequest;

  // Slave to master, datR only valid with ack
  typedef struct packed {
    logic        ack;
    logic [15:0] datR;
  } wbResponse;

  // Register map
  // Mode in bits 1..0
  localparam logic [1:0] regControl    = 2'd0;
  // 12-bit colours
  localparam logic [1:0] regFgColor    = 2'd1;
  localparam logic [1:0] regBgColor    = 2'd2;
  // Read only, wraps at 16 bits
  localparam logic [1:0] regFrameCount = 2'd3;

  localparam logic [11:0] fgColorReset = 12'hfff;
  localparam logic [11:0] bgColorReset = 12'h000;

endpackage

//--- rtl/vgaTimingPkg.sv
// ==========================================================================
// Pixel pipeline types shared by the timing, pattern and output stages
// Referenced by scoped name from each module that needs them
// ==========================================================================
package vgaTimingPkg;

  // 12-bit colour, 4 bits per channel
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgbPixel;

  // Current counter position from the timing generator
  typedef struct packed {
    logic [10:0] x;
    logic [9:0]  y;
    logic        displayArea;
  } scanPos;

  // One pixel slot as it moves towards the pins
  typedef struct packed {
    logic    displayArea;
    logic    hSync;
    logic    vSync;
    rgbPixel colour;
  } pixelBeat;

  typedef enum logic [1:0] {
    modeSolid    = 2'd0,
    modeChecker  = 2'd1,
    modeGradient = 2'd2
  } patternMode;

endpackage
